/* hw/tdc_pkg.sv */
package tdc_pkg;

	// measurement widths
	localparam int COUNTER_BITS = 10;
	localparam int ENCODE_BITS = 7;
	localparam int FINE_BITS = 2;
	localparam int TDL_TAPS = 96;
	localparam int TS_BITS = 16;

	// tap encoder adds the snapshot up in groups
	localparam int TDL_GROUP_TAPS = 8;
	localparam int TDL_GROUPS = TDL_TAPS / TDL_GROUP_TAPS;
	localparam int TDL_GROUP_BITS = $clog2(TDL_GROUP_TAPS + 1);
	localparam int TDL_SUM_BITS = $clog2(TDL_TAPS + 1);
	localparam logic [TDL_SUM_BITS-1:0] ENCODE_MAX = TDL_SUM_BITS'((2 ** ENCODE_BITS) - 1);

	// data word layout
	localparam int WORD_BITS = 32;
	localparam int PAYLOAD_BITS = 25;
	localparam int COARSE_FIELD_BITS = 16;
	localparam logic [3:0] DATA_IDENTIFIER = 4'b0100;
	localparam logic [COARSE_FIELD_BITS-1:0] OVERFLOW_COARSE =
		COARSE_FIELD_BITS'((2 ** (COUNTER_BITS - 1)) - 1);

	// word queue
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_RESERVE = 3;
	localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
	localparam int FIFO_COUNT_BITS = FIFO_PTR_BITS + 1;
	localparam logic [FIFO_COUNT_BITS-1:0] FIFO_COUNT_FULL = FIFO_COUNT_BITS'(FIFO_DEPTH);
	localparam logic [FIFO_COUNT_BITS-1:0] FIFO_COUNT_AFULL =
		FIFO_COUNT_BITS'(FIFO_DEPTH - FIFO_RESERVE);

	typedef enum logic [3:0] {
		IDLE      = 4'd0,
		IDLE_TRIG = 4'd1,
		TRIGGERED = 4'd2,
		RIS_EDGE  = 4'd3,
		FAL_EDGE  = 4'd4,
		FIFO_FULL = 4'd5,
		MISSED    = 4'd6,
		CALIB     = 4'd7,
		CALIB_HIT = 4'd8,
		RESET     = 4'd9
	} tdc_state_e;

	typedef enum logic [2:0] {
		TRIGGERED_WORD = 3'd0,
		RISING_WORD    = 3'd1,
		FALLING_WORD   = 3'd2,
		TIMESTAMP_WORD = 3'd3,
		CALIB_WORD     = 3'd4,
		MISS_WORD      = 3'd5,
		RESET_WORD     = 3'd6
	} word_type_e;

endpackage

/* hw/tdl_encoder.sv */
`timescale 1ns/1ps

module tdl_encoder (
	input  logic [tdc_pkg::TDL_TAPS-1:0]    tdl_taps,
	output logic [tdc_pkg::ENCODE_BITS-1:0] tdl_code
);

	logic [tdc_pkg::TDL_GROUP_BITS-1:0] group_count [tdc_pkg::TDL_GROUPS];
	logic [tdc_pkg::TDL_SUM_BITS-1:0]   total;

	// ones count per group of taps
	// a bubble only moves the result by one tap, where a priority
	// search for the edge would jump to the bubble position
	always_comb begin
		for (int g = 0; g < tdc_pkg::TDL_GROUPS; g++) begin
			group_count[g] = '0;
			for (int t = 0; t < tdc_pkg::TDL_GROUP_TAPS; t++) begin
				group_count[g] = group_count[g] + {
					{(tdc_pkg::TDL_GROUP_BITS - 1){1'b0}},
					tdl_taps[g * tdc_pkg::TDL_GROUP_TAPS + t]
				};
			end
		end
	end

	// sum of the groups
	always_comb begin
		total = '0;
		for (int g = 0; g < tdc_pkg::TDL_GROUPS; g++) begin
			total = total + {
				{(tdc_pkg::TDL_SUM_BITS - tdc_pkg::TDL_GROUP_BITS){1'b0}},
				group_count[g]
			};
		end
	end

	// clamp to the code width
	always_comb begin
		if (total > tdc_pkg::ENCODE_MAX) begin
			tdl_code = '1;
		end else begin
			tdl_code = total[tdc_pkg::ENCODE_BITS-1:0];
		end
	end

endmodule

/* hw/tdc_channel_fsm.sv */
`timescale 1ns/1ps

module tdc_channel_fsm (
	input  logic                              CLK,
	input  logic                              rst_n,
	input  logic                              sig,
	input  logic                              trig,
	input  logic                              calib_start,
	input  logic                              soft_reset,
	input  logic                              fifo_almost_full,
	input  logic [tdc_pkg::ENCODE_BITS-1:0]   tdl_code,
	input  logic [tdc_pkg::FINE_BITS-1:0]     fine_phase,
	output tdc_pkg::tdc_state_e               tdc_state,
	output logic [tdc_pkg::COUNTER_BITS-1:0]  coarse_count,
	output logic [tdc_pkg::FINE_BITS-1:0]     fine_time,
	output logic [tdc_pkg::ENCODE_BITS-1:0]   tdl_time,
	output logic [tdc_pkg::TS_BITS-1:0]       signal_timestamp,
	output logic [tdc_pkg::TS_BITS-1:0]       reset_timestamp
);

	tdc_pkg::tdc_state_e          state_next;
	logic                         sig_d;
	logic                         rise;
	logic                         fall;
	logic                         capture;
	logic                         coarse_clear;
	logic                         miss_reported;
	logic [tdc_pkg::TS_BITS-1:0]  ts_count;
	logic [tdc_pkg::TS_BITS-1:0]  ts_next;

	assign rise = sig & ~sig_d;
	assign fall = ~sig & sig_d;
	assign ts_next = ts_count + 1'b1;

	always_comb begin
		state_next = tdc_state;
		if (soft_reset) begin
			state_next = tdc_pkg::RESET;
		end else begin
			case (tdc_state)
				tdc_pkg::IDLE: begin
					if (trig) state_next = tdc_pkg::IDLE_TRIG;
					else if (calib_start) state_next = tdc_pkg::CALIB;
					else if (fifo_almost_full) state_next = tdc_pkg::FIFO_FULL;
					else if (rise) state_next = tdc_pkg::RIS_EDGE;
				end
				tdc_pkg::IDLE_TRIG: state_next = tdc_pkg::TRIGGERED;
				tdc_pkg::TRIGGERED: if (rise) state_next = tdc_pkg::RIS_EDGE;
				tdc_pkg::RIS_EDGE: if (fall) state_next = tdc_pkg::FAL_EDGE;
				tdc_pkg::FAL_EDGE: state_next = trig ? tdc_pkg::IDLE_TRIG : tdc_pkg::IDLE;
				tdc_pkg::CALIB: if (rise) state_next = tdc_pkg::CALIB_HIT;
				tdc_pkg::FIFO_FULL: begin
					// only the first hit of a full episode is reported
					if (!fifo_almost_full) state_next = tdc_pkg::IDLE;
					else if (rise && !miss_reported) state_next = tdc_pkg::MISSED;
				end
				default: state_next = tdc_pkg::IDLE;
			endcase
		end
	end

	// phase and taps are latched on entry to a measuring state
	assign capture = (state_next != tdc_state) &&
		(state_next inside {tdc_pkg::IDLE_TRIG, tdc_pkg::RIS_EDGE,
			tdc_pkg::FAL_EDGE, tdc_pkg::CALIB_HIT});
	assign coarse_clear = (state_next == tdc_pkg::IDLE_TRIG) ||
		(tdc_state == tdc_pkg::IDLE && state_next == tdc_pkg::RIS_EDGE);

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			tdc_state <= tdc_pkg::IDLE;
			sig_d <= 1'b0;
			coarse_count <= '0;
			ts_count <= '0;
			miss_reported <= 1'b0;
		end else begin
			tdc_state <= state_next;
			sig_d <= sig;
			// top bit is the overflow flag, count holds there
			if (coarse_clear) coarse_count <= '0;
			else if (!coarse_count[tdc_pkg::COUNTER_BITS-1]) coarse_count <= coarse_count + 1'b1;
			ts_count <= soft_reset ? '0 : ts_next;
			if (!fifo_almost_full) miss_reported <= 1'b0;
			else if (state_next == tdc_pkg::MISSED) miss_reported <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (capture) begin
			fine_time <= fine_phase;
			tdl_time <= tdl_code;
		end
		if (state_next == tdc_pkg::RIS_EDGE && tdc_state != tdc_pkg::RIS_EDGE) begin
			signal_timestamp <= ts_next;
		end
		if (soft_reset) begin
			reset_timestamp <= ts_next;
		end
	end

	a_state_legal: assert property (@(posedge CLK) disable iff (!rst_n)
		$unsigned(tdc_state) <= $unsigned(tdc_pkg::RESET));

endmodule

/* hw/word_broker.sv */
`timescale 1ns/1ps

module word_broker (
	input  logic                              CLK,
	input  logic                              rst_n,
	input  tdc_pkg::tdc_state_e               tdc_state,
	input  logic [tdc_pkg::COUNTER_BITS-1:0]  coarse_count,
	input  logic [tdc_pkg::FINE_BITS-1:0]     fine_time,
	input  logic [tdc_pkg::ENCODE_BITS-1:0]   tdl_time,
	input  logic [tdc_pkg::TS_BITS-1:0]       signal_timestamp,
	input  logic [tdc_pkg::TS_BITS-1:0]       reset_timestamp,
	input  logic                              en_write_timestamp,
	output logic                              word_valid,
	output logic [tdc_pkg::WORD_BITS-1:0]     word
);

	tdc_pkg::tdc_state_e                     prev_state;
	tdc_pkg::word_type_e                     next_type;
	logic                                    next_valid;
	logic [tdc_pkg::PAYLOAD_BITS-1:0]        next_payload;
	logic [tdc_pkg::COARSE_FIELD_BITS-1:0]   coarse_field;
	logic                                    overflow;
	logic [tdc_pkg::PAYLOAD_BITS-1:0]        meas_raw;
	logic [tdc_pkg::PAYLOAD_BITS-1:0]        meas_checked;
	logic [tdc_pkg::PAYLOAD_BITS-1:0]        calib_payload;
	logic [tdc_pkg::PAYLOAD_BITS-1:0]        signal_ts_payload;
	logic [tdc_pkg::PAYLOAD_BITS-1:0]        reset_ts_payload;

	assign overflow = coarse_count[tdc_pkg::COUNTER_BITS-1];
	assign coarse_field = {
		{(tdc_pkg::COARSE_FIELD_BITS - tdc_pkg::COUNTER_BITS){1'b0}},
		coarse_count
	};

	assign meas_raw = {coarse_field, fine_time, tdl_time};
	// saturated coarse and fine, tap code still valid
	assign meas_checked = overflow ?
		{tdc_pkg::OVERFLOW_COARSE, {tdc_pkg::FINE_BITS{1'b1}}, tdl_time} : meas_raw;
	assign calib_payload = {{tdc_pkg::COARSE_FIELD_BITS{1'b0}}, fine_time, tdl_time};
	assign signal_ts_payload = {
		signal_timestamp, {(tdc_pkg::PAYLOAD_BITS - tdc_pkg::TS_BITS){1'b0}}
	};
	assign reset_ts_payload = {
		reset_timestamp, {(tdc_pkg::PAYLOAD_BITS - tdc_pkg::TS_BITS){1'b0}}
	};

	// one word per state transition
	always_comb begin
		next_valid = 1'b0;
		next_type = tdc_pkg::TRIGGERED_WORD;
		next_payload = '0;
		case ({prev_state, tdc_state})
			{tdc_pkg::IDLE_TRIG, tdc_pkg::TRIGGERED}: begin
				next_valid = 1'b1;
				next_type = tdc_pkg::TRIGGERED_WORD;
				next_payload = meas_raw;
			end
			{tdc_pkg::IDLE, tdc_pkg::RIS_EDGE}: begin
				next_valid = 1'b1;
				next_type = tdc_pkg::RISING_WORD;
				next_payload = meas_raw;
			end
			{tdc_pkg::TRIGGERED, tdc_pkg::RIS_EDGE}: begin
				next_valid = 1'b1;
				next_type = tdc_pkg::RISING_WORD;
				next_payload = meas_checked;
			end
			{tdc_pkg::RIS_EDGE, tdc_pkg::FAL_EDGE}: begin
				next_valid = 1'b1;
				next_type = tdc_pkg::FALLING_WORD;
				next_payload = meas_checked;
			end
			{tdc_pkg::FAL_EDGE, tdc_pkg::IDLE}, {tdc_pkg::FAL_EDGE, tdc_pkg::IDLE_TRIG}: begin
				next_valid = en_write_timestamp;
				next_type = tdc_pkg::TIMESTAMP_WORD;
				next_payload = signal_ts_payload;
			end
			{tdc_pkg::MISSED, tdc_pkg::IDLE}: begin
				next_valid = 1'b1;
				next_type = tdc_pkg::MISS_WORD;
			end
			{tdc_pkg::RESET, tdc_pkg::IDLE}: begin
				next_valid = 1'b1;
				next_type = tdc_pkg::RESET_WORD;
				next_payload = reset_ts_payload;
			end
			{tdc_pkg::CALIB, tdc_pkg::CALIB_HIT}: begin
				next_valid = 1'b1;
				next_type = tdc_pkg::CALIB_WORD;
				next_payload = calib_payload;
			end
			default: next_valid = 1'b0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			prev_state <= tdc_pkg::IDLE;
			word_valid <= 1'b0;
		end else begin
			prev_state <= tdc_state;
			word_valid <= next_valid;
		end
	end

	always_ff @(posedge CLK) begin
		word <= next_valid ? {tdc_pkg::DATA_IDENTIFIER, next_type, next_payload} : '0;
	end

	// back-to-back strobes only come from different transitions
	a_single_strobe: assert property (@(posedge CLK) disable iff (!rst_n)
		word_valid |=> !word_valid || (word != $past(word)));

endmodule

/* hw/word_fifo.sv */
`timescale 1ns/1ps

module word_fifo (
	input  logic                                 CLK,
	input  logic                                 rst_n,
	input  logic                                 word_valid,
	input  logic [tdc_pkg::WORD_BITS-1:0]        word,
	input  logic                                 rd_en,
	output logic [tdc_pkg::WORD_BITS-1:0]        rd_word,
	output logic                                 rd_empty,
	output logic [tdc_pkg::FIFO_COUNT_BITS-1:0]  fifo_count,
	output logic                                 fifo_almost_full
);

	logic [tdc_pkg::WORD_BITS-1:0]      mem [tdc_pkg::FIFO_DEPTH];
	logic [tdc_pkg::FIFO_PTR_BITS-1:0]  wr_ptr;
	logic [tdc_pkg::FIFO_PTR_BITS-1:0]  rd_ptr;
	logic                               do_write;
	logic                               do_read;

	assign rd_empty = (fifo_count == '0);
	assign fifo_almost_full = (fifo_count >= tdc_pkg::FIFO_COUNT_AFULL);
	assign do_write = word_valid && (fifo_count != tdc_pkg::FIFO_COUNT_FULL);
	assign do_read = rd_en && !rd_empty;

	// show-ahead head word
	assign rd_word = mem[rd_ptr];

	always_ff @(posedge CLK) begin
		if (do_write) begin
			mem[wr_ptr] <= word;
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_count <= '0;
		end else begin
			if (do_write) wr_ptr <= wr_ptr + 1'b1;
			if (do_read) rd_ptr <= rd_ptr + 1'b1;
			case ({do_write, do_read})
				2'b10: fifo_count <= fifo_count + 1'b1;
				2'b01: fifo_count <= fifo_count - 1'b1;
				default: fifo_count <= fifo_count;
			endcase
		end
	end

	// the reserve slots must absorb everything the channel still sends
	a_no_overflow: assert property (@(posedge CLK) disable iff (!rst_n)
		!(word_valid && fifo_count == tdc_pkg::FIFO_COUNT_FULL));

endmodule

/* hw/tdc_top.sv */
`timescale 1ns/1ps

module tdc_top (
	input  logic                                 CLK,
	input  logic                                 rst_n,
	input  logic                                 sig,
	input  logic                                 trig,
	input  logic                                 calib_start,
	input  logic                                 soft_reset,
	input  logic [tdc_pkg::TDL_TAPS-1:0]         tdl_taps,
	input  logic [tdc_pkg::FINE_BITS-1:0]        fine_phase,
	input  logic                                 en_write_timestamp,
	input  logic                                 rd_en,
	output logic [tdc_pkg::WORD_BITS-1:0]        rd_word,
	output logic                                 rd_empty,
	output logic [tdc_pkg::FIFO_COUNT_BITS-1:0]  fifo_count
);

	logic [tdc_pkg::ENCODE_BITS-1:0]   tdl_code;
	tdc_pkg::tdc_state_e               tdc_state;
	logic [tdc_pkg::COUNTER_BITS-1:0]  coarse_count;
	logic [tdc_pkg::FINE_BITS-1:0]     fine_time;
	logic [tdc_pkg::ENCODE_BITS-1:0]   tdl_time;
	logic [tdc_pkg::TS_BITS-1:0]       signal_timestamp;
	logic [tdc_pkg::TS_BITS-1:0]       reset_timestamp;
	logic                              word_valid;
	logic [tdc_pkg::WORD_BITS-1:0]     word;
	logic                              fifo_almost_full;

	tdl_encoder i_encoder (
		.tdl_taps (tdl_taps),
		.tdl_code (tdl_code)
	);

	tdc_channel_fsm i_fsm (
		.CLK              (CLK),
		.rst_n            (rst_n),
		.sig              (sig),
		.trig             (trig),
		.calib_start      (calib_start),
		.soft_reset       (soft_reset),
		.fifo_almost_full (fifo_almost_full),
		.tdl_code         (tdl_code),
		.fine_phase       (fine_phase),
		.tdc_state        (tdc_state),
		.coarse_count     (coarse_count),
		.fine_time        (fine_time),
		.tdl_time         (tdl_time),
		.signal_timestamp (signal_timestamp),
		.reset_timestamp  (reset_timestamp)
	);

	word_broker i_broker (
		.CLK                (CLK),
		.rst_n              (rst_n),
		.tdc_state          (tdc_state),
		.coarse_count       (coarse_count),
		.fine_time          (fine_time),
		.tdl_time           (tdl_time),
		.signal_timestamp   (signal_timestamp),
		.reset_timestamp    (reset_timestamp),
		.en_write_timestamp (en_write_timestamp),
		.word_valid         (word_valid),
		.word               (word)
	);

	word_fifo i_fifo (
		.CLK              (CLK),
		.rst_n            (rst_n),
		.word_valid       (word_valid),
		.word             (word),
		.rd_en            (rd_en),
		.rd_word          (rd_word),
		.rd_empty         (rd_empty),
		.fifo_count       (fifo_count),
		.fifo_almost_full (fifo_almost_full)
	);

endmodule

/* dv/tdc_tb.sv */
`timescale 1ns/1ps

module tdc_tb;

	logic                                 CLK;
	logic                                 rst_n;
	logic                                 sig;
	logic                                 trig;
	logic                                 calib_start;
	logic                                 soft_reset;
	logic [tdc_pkg::TDL_TAPS-1:0]         tdl_taps;
	logic [tdc_pkg::FINE_BITS-1:0]        fine_phase;
	logic                                 en_write_timestamp;
	logic                                 rd_en;
	logic [tdc_pkg::WORD_BITS-1:0]        rd_word;
	logic                                 rd_empty;
	logic [tdc_pkg::FIFO_COUNT_BITS-1:0]  fifo_count;

	integer       seed;
	int           error_count;
	int           check_count;
	logic [31:0]  last_word;

	tdc_top i_dut (
		.CLK                (CLK),
		.rst_n              (rst_n),
		.sig                (sig),
		.trig               (trig),
		.calib_start        (calib_start),
		.soft_reset         (soft_reset),
		.tdl_taps           (tdl_taps),
		.fine_phase         (fine_phase),
		.en_write_timestamp (en_write_timestamp),
		.rd_en              (rd_en),
		.rd_word            (rd_word),
		.rd_empty           (rd_empty),
		.fifo_count         (fifo_count)
	);

	always #20 CLK = ~CLK;

	// inputs change 1 ns after the rising edge
	task automatic step(input int n);
		repeat (n) begin
			@(posedge CLK);
			#1;
		end
	endtask

	task automatic mismatch(input string name, input string field, input logic [31:0] exp,
		input logic [31:0] act);
		error_count++;
		$display("ERROR %s %s: expected %h, actual %h", name, field, exp, act);
	endtask

	// thermometer code with one bubble below the edge and a stray tap above it
	task automatic new_taps(output logic [tdc_pkg::TDL_TAPS-1:0] t);
		int len;
		len = 8 + int'({$random(seed)} % 80);
		t = '0;
		for (int i = 0; i < len; i++) begin
			t[i] = 1'b1;
		end
		t[len - 3] = 1'b0;
		t[len + 2] = 1'b1;
	endtask

	function automatic logic [6:0] count_ones(input logic [tdc_pkg::TDL_TAPS-1:0] t);
		logic [6:0] n;
		n = '0;
		for (int i = 0; i < tdc_pkg::TDL_TAPS; i++) begin
			n = n + 7'(t[i]);
		end
		return n;
	endfunction

	// coarse, fine, tdl code; past 511 the overflow bit is set
	function automatic logic [24:0] measurement(input int coarse, input logic [1:0] phase,
		input logic [6:0] code);
		logic [24:0] p;
		if (coarse > 511) begin
			p = {16'd511, 2'd3, code};
		end else begin
			p = {16'(coarse), phase, code};
		end
		return p;
	endfunction

	task automatic pop_check(input string name, input logic [2:0] typ,
		input logic [24:0] payload, input logic [24:0] mask);
		int waited;
		waited = 0;
		while (rd_empty && waited < 40) begin
			step(1);
			waited++;
		end
		check_count++;
		if (rd_empty) begin
			error_count++;
			$display("%s: no word arrived in the FIFO within 40 cycles", name);
			last_word = '0;
		end else begin
			last_word = rd_word;
			rd_en = 1'b1;
			step(1);
			rd_en = 1'b0;
			if (last_word[31:28] !== tdc_pkg::DATA_IDENTIFIER) begin
				mismatch(name, "identifier", 32'(tdc_pkg::DATA_IDENTIFIER), 32'(last_word[31:28]));
			end
			if (last_word[27:25] !== typ) begin
				mismatch(name, "type", 32'(typ), 32'(last_word[27:25]));
			end
			if ((last_word[24:0] & mask) !== (payload & mask)) begin
				mismatch(name, "payload", 32'(payload & mask), 32'(last_word[24:0] & mask));
			end
		end
	endtask

	task automatic expect_empty(input string name);
		step(4);
		check_count++;
		if (rd_empty !== 1'b1) begin
			mismatch(name, "rd_empty", 32'd1, 32'(rd_empty));
		end
	endtask

	task automatic test_untriggered(input string name, input logic ts_en, input int width);
		logic [tdc_pkg::TDL_TAPS-1:0] rise_taps;
		logic [tdc_pkg::TDL_TAPS-1:0] fall_taps;
		logic [1:0]                   rise_phase;
		logic [1:0]                   fall_phase;
		en_write_timestamp = ts_en;
		new_taps(rise_taps);
		new_taps(fall_taps);
		rise_phase = 2'($random(seed));
		fall_phase = 2'($random(seed));
		tdl_taps = rise_taps;
		fine_phase = rise_phase;
		sig = 1'b1;
		step(width);
		tdl_taps = fall_taps;
		fine_phase = fall_phase;
		sig = 1'b0;
		step(4);
		pop_check(name, tdc_pkg::RISING_WORD, measurement(0, rise_phase, count_ones(rise_taps)), '1);
		pop_check(name, tdc_pkg::FALLING_WORD,
			measurement(width, fall_phase, count_ones(fall_taps)), '1);
		if (ts_en) begin
			pop_check(name, tdc_pkg::TIMESTAMP_WORD, 25'd0, 25'h1ff);
		end
		expect_empty(name);
	endtask

	task automatic test_triggered(input string name, input int delay);
		logic [tdc_pkg::TDL_TAPS-1:0] trig_taps;
		logic [tdc_pkg::TDL_TAPS-1:0] rise_taps;
		logic [1:0]                   trig_phase;
		logic [1:0]                   rise_phase;
		en_write_timestamp = 1'b0;
		new_taps(trig_taps);
		new_taps(rise_taps);
		trig_phase = 2'($random(seed));
		rise_phase = 2'($random(seed));
		tdl_taps = trig_taps;
		fine_phase = trig_phase;
		trig = 1'b1;
		step(1);
		trig = 1'b0;
		step(delay - 1);
		tdl_taps = rise_taps;
		fine_phase = rise_phase;
		sig = 1'b1;
		step(3);
		sig = 1'b0;
		step(4);
		pop_check(name, tdc_pkg::TRIGGERED_WORD, {16'd1, trig_phase, count_ones(trig_taps)}, '1);
		pop_check(name, tdc_pkg::RISING_WORD,
			measurement(delay, rise_phase, count_ones(rise_taps)), '1);
		pop_check(name, tdc_pkg::FALLING_WORD,
			measurement(delay + 3, rise_phase, count_ones(rise_taps)), '1);
		expect_empty(name);
	endtask

	task automatic test_calibration();
		logic [tdc_pkg::TDL_TAPS-1:0] taps;
		logic [1:0]                   phase;
		new_taps(taps);
		phase = 2'($random(seed));
		calib_start = 1'b1;
		step(1);
		calib_start = 1'b0;
		step(2);
		tdl_taps = taps;
		fine_phase = phase;
		sig = 1'b1;
		step(3);
		sig = 1'b0;
		step(4);
		pop_check("calibration", tdc_pkg::CALIB_WORD, {16'd0, phase, count_ones(taps)}, '1);
		expect_empty("calibration");
	endtask

	// rises 10 cycles apart, soft reset 8 cycles after the second rise, rise 5 after reset
	task automatic test_timestamps();
		logic [15:0] first_ts;
		logic [15:0] second_ts;
		en_write_timestamp = 1'b1;
		sig = 1'b1;
		step(3);
		sig = 1'b0;
		step(7);
		sig = 1'b1;
		step(3);
		sig = 1'b0;
		step(5);
		soft_reset = 1'b1;
		step(1);
		soft_reset = 1'b0;
		step(4);
		sig = 1'b1;
		step(3);
		sig = 1'b0;
		step(4);
		pop_check("timestamps", tdc_pkg::RISING_WORD, 25'd0, 25'h1ff_fe00);
		pop_check("timestamps", tdc_pkg::FALLING_WORD, {16'd3, 9'd0}, 25'h1ff_fe00);
		pop_check("timestamps", tdc_pkg::TIMESTAMP_WORD, 25'd0, 25'h1ff);
		first_ts = last_word[24:9];
		pop_check("timestamps", tdc_pkg::RISING_WORD, 25'd0, 25'h1ff_fe00);
		pop_check("timestamps", tdc_pkg::FALLING_WORD, {16'd3, 9'd0}, 25'h1ff_fe00);
		pop_check("timestamps", tdc_pkg::TIMESTAMP_WORD, {first_ts + 16'd10, 9'd0}, '1);
		second_ts = last_word[24:9];
		pop_check("timestamps", tdc_pkg::RESET_WORD, {second_ts + 16'd8, 9'd0}, '1);
		pop_check("timestamps", tdc_pkg::RISING_WORD, 25'd0, 25'h1ff_fe00);
		pop_check("timestamps", tdc_pkg::FALLING_WORD, {16'd3, 9'd0}, 25'h1ff_fe00);
		pop_check("timestamps", tdc_pkg::TIMESTAMP_WORD, {16'd5, 9'd0}, '1);
		expect_empty("timestamps");
	endtask

	task automatic test_backpressure();
		en_write_timestamp = 1'b1;
		repeat (7) begin
			sig = 1'b1;
			step(3);
			sig = 1'b0;
			step(8);
		end
		check_count++;
		if (fifo_count !== 5'(tdc_pkg::FIFO_DEPTH)) begin
			mismatch("backpressure", "fifo_count", 32'(tdc_pkg::FIFO_DEPTH), 32'(fifo_count));
		end
		repeat (5) begin
			pop_check("backpressure", tdc_pkg::RISING_WORD, 25'd0, 25'h1ff_fe00);
			pop_check("backpressure", tdc_pkg::FALLING_WORD, {16'd3, 9'd0}, 25'h1ff_fe00);
			pop_check("backpressure", tdc_pkg::TIMESTAMP_WORD, 25'd0, 25'h1ff);
		end
		pop_check("backpressure", tdc_pkg::MISS_WORD, 25'd0, '1);
		expect_empty("backpressure");
		test_untriggered("after backpressure", 1'b1, 5);
	endtask

	initial begin
		CLK = 1'b0;
		rst_n = 1'b0;
		sig = 1'b0;
		trig = 1'b0;
		calib_start = 1'b0;
		soft_reset = 1'b0;
		tdl_taps = '0;
		fine_phase = '0;
		en_write_timestamp = 1'b0;
		rd_en = 1'b0;
		seed = 79;
		error_count = 0;
		check_count = 0;
		last_word = '0;
		repeat (4) @(posedge CLK);
		#1;
		rst_n = 1'b1;
		step(2);
		test_untriggered("untriggered", 1'b1, 7);
		test_untriggered("untriggered no timestamp", 1'b0, 12);
		test_triggered("triggered", 20);
		test_triggered("overflow", 600);
		test_calibration();
		test_timestamps();
		test_backpressure();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* build.f */
hw/tdc_pkg.sv
hw/tdl_encoder.sv
hw/tdc_channel_fsm.sv
hw/word_broker.sv
hw/word_fifo.sv
hw/tdc_top.sv
dv/tdc_tb.sv

/* Makefile */
TOP := tdc_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
